//--- vlog.f
+incdir+testbench
hw/rv_isa_pkg.sv
hw/pipe_ctrl_pkg.sv
hw/fetch_sequencer.sv
hw/inst_pipeline.sv
hw/forward_detect.sv
hw/operand_read_ctrl.sv
hw/execute_ctrl.sv
hw/mem_wb_ctrl.sv
hw/pipeline_ctrl_top.sv
testbench/tb_pipeline_ctrl.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the pipeline control testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_pipeline_ctrl \
    -f vlog.f -o tb_sim \
    && ./obj_dir/tb_sim | tee /dev/stderr | grep -x "NO ERRORS" > /dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

//--- testbench/tb_program.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

////////////////////////////////////////
// Instruction encoders
////////////////////////////////////////

function automatic rv_isa_pkg::inst_t r_word(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                             logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, rv_isa_pkg::OPC_OP};
endfunction

function automatic rv_isa_pkg::inst_t i_word(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                             logic [4:0] rd, rv_isa_pkg::opcode_t opc);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic rv_isa_pkg::inst_t s_word(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                             logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], rv_isa_pkg::OPC_STORE};
endfunction

// Branch offset in bytes, bit 0 dropped
function automatic rv_isa_pkg::inst_t b_word(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                             logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_isa_pkg::OPC_BRANCH};
endfunction

function automatic rv_isa_pkg::inst_t u_word(logic [19:0] imm, logic [4:0] rd,
                                             rv_isa_pkg::opcode_t opc);
    return {imm, rd, opc};
endfunction

function automatic rv_isa_pkg::inst_t j_word(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_isa_pkg::OPC_JAL};
endfunction

////////////////////////////////////////
// Program image
////////////////////////////////////////

task automatic load_program();
    rv_isa_pkg::inst_t w;
    rv_isa_pkg::opcode_t opc_list [9];
    int pick;
    opc_list = '{rv_isa_pkg::OPC_LUI, rv_isa_pkg::OPC_AUIPC, rv_isa_pkg::OPC_JAL,
                 rv_isa_pkg::OPC_JALR, rv_isa_pkg::OPC_BRANCH, rv_isa_pkg::OPC_LOAD,
                 rv_isa_pkg::OPC_STORE, rv_isa_pkg::OPC_OP_IMM, rv_isa_pkg::OPC_OP};
    // Load then use through rs1, then through rs2
    rom[0] = i_word(12'h000, 5'd1, 3'b010, 5'd5, rv_isa_pkg::OPC_LOAD);
    rom[1] = r_word(7'h00, 5'd2, 5'd5, 3'b000, 5'd6);
    rom[2] = i_word(12'h004, 5'd1, 3'b010, 5'd7, rv_isa_pkg::OPC_LOAD);
    rom[3] = r_word(7'h20, 5'd7, 5'd3, 3'b000, 5'd8);
    // LUI after a load, its rs1 bit field matches but it reads nothing
    rom[4] = i_word(12'h008, 5'd2, 3'b100, 5'd9, rv_isa_pkg::OPC_LOAD);
    rom[5] = u_word(20'h1234d, 5'd10, rv_isa_pkg::OPC_LUI);
    // Back to back producers for both forwarding distances
    rom[6] = i_word(12'h001, 5'd10, 3'b000, 5'd11, rv_isa_pkg::OPC_OP_IMM);
    rom[7] = r_word(7'h00, 5'd11, 5'd11, 3'b000, 5'd12);
    rom[8] = r_word(7'h00, 5'd11, 5'd12, 3'b111, 5'd13);
    // Remaining formats
    rom[9] = u_word(20'habcde, 5'd14, rv_isa_pkg::OPC_AUIPC);
    rom[10] = j_word(21'h05a6c, 5'd1);
    rom[11] = i_word(12'hffc, 5'd1, 3'b000, 5'd0, rv_isa_pkg::OPC_JALR);
    rom[12] = b_word(13'h1a5e, 5'd13, 5'd12, 3'b001);
    rom[13] = s_word(12'h7f4, 5'd13, 5'd14, 3'b010);
    // Store and branch waiting on a load through rs2
    rom[14] = i_word(12'h010, 5'd13, 3'b010, 5'd15, rv_isa_pkg::OPC_LOAD);
    rom[15] = s_word(12'h004, 5'd15, 5'd14, 3'b010);
    rom[16] = i_word(12'h000, 5'd15, 3'b010, 5'd16, rv_isa_pkg::OPC_LOAD);
    rom[17] = b_word(13'h0010, 5'd16, 5'd0, 3'b000);
    // Chain of loads, each one stalls on the one before
    rom[18] = i_word(12'h000, 5'd16, 3'b001, 5'd17, rv_isa_pkg::OPC_LOAD);
    rom[19] = i_word(12'h000, 5'd17, 3'b010, 5'd18, rv_isa_pkg::OPC_LOAD);
    rom[20] = i_word(12'h000, 5'd18, 3'b000, 5'd19, rv_isa_pkg::OPC_JALR);
    // Random filler on the supported opcodes
    seed = 32'he1aa;
    for (int k = DIRECTED_LEN; k < PROG_LEN; k++)
    begin
        w = $random(seed);
        pick = int'($unsigned($random(seed)) % 32'd9);
        w[6:0] = opc_list[pick];
        // Few registers so that hazards and forwarding come up often
        w[11:7] = {2'b00, w[9:7]};
        w[19:15] = {2'b00, w[17:15]};
        w[24:20] = {2'b00, w[22:20]};
        rom[k] = w;
    end
endtask

`endif

//--- testbench/tb_pipeline_ctrl.sv
`timescale 1ns/1ps

module tb_pipeline_ctrl;

    // ROM size is a power of two
    localparam int ROM_AW = 6;
    localparam int PROG_LEN = 1 << ROM_AW;
    localparam int DIRECTED_LEN = 21;
    // Up to two cycles per word plus reset and drain
    localparam int TIMEOUT_CYCLES = 2 * PROG_LEN + 20;
    localparam pipe_ctrl_pkg::pc_t END_PC = PROG_LEN * 4;

    logic clk = 1'b0;
    logic arst_n = 1'b0;
    rv_isa_pkg::inst_t inst;
    pipe_ctrl_pkg::pc_t pc;
    rv_isa_pkg::reg_addr_t addr1;
    rv_isa_pkg::reg_addr_t addr2;
    logic rd1;
    logic rd2;
    rv_isa_pkg::opcode_t dp_ctrl;
    rv_isa_pkg::funct3_t funct3;
    pipe_ctrl_pkg::imm_t immediate;
    pipe_ctrl_pkg::fwd_sel_t fwd_sel1;
    pipe_ctrl_pkg::fwd_sel_t fwd_sel2;
    rv_isa_pkg::opcode_t mem_ctrl;
    rv_isa_pkg::funct3_t mem_funct3;
    rv_isa_pkg::reg_addr_t addr3;
    logic wr;

    // Program memory and random source
    rv_isa_pkg::inst_t rom [PROG_LEN];
    integer seed;

    int err_count = 0;
    int stall_count = 0;
    int cycle_count = 0;

    // Reference model state
    pipe_ctrl_pkg::pc_t exp_pc = '0;
    logic stall_q = 1'b0;
    logic stall_now;
    rv_isa_pkg::inst_t fetched;
    // Index k holds the word accepted k edges ago
    rv_isa_pkg::inst_t hist [$];
    // Bit k set when the word accepted k edges ago was a stall bubble
    logic [3:0] bubble_hist = '0;

    // Expected outputs after the latest edge
    rv_isa_pkg::reg_addr_t exp_addr1;
    rv_isa_pkg::reg_addr_t exp_addr2;
    logic exp_rd1;
    logic exp_rd2;
    rv_isa_pkg::opcode_t exp_dp;
    rv_isa_pkg::funct3_t exp_f3;
    pipe_ctrl_pkg::imm_t exp_imm;
    pipe_ctrl_pkg::fwd_sel_t exp_fwd1;
    pipe_ctrl_pkg::fwd_sel_t exp_fwd2;
    rv_isa_pkg::opcode_t exp_mem;
    rv_isa_pkg::funct3_t exp_mf3;
    rv_isa_pkg::reg_addr_t exp_addr3;
    logic exp_wr;

    `include "tb_program.svh"

    pipeline_ctrl_top u_dut
    (
        .clk        (clk),
        .arst_n     (arst_n),
        .inst       (inst),
        .pc         (pc),
        .addr1      (addr1),
        .addr2      (addr2),
        .rd1        (rd1),
        .rd2        (rd2),
        .dp_ctrl    (dp_ctrl),
        .funct3     (funct3),
        .immediate  (immediate),
        .fwd_sel1   (fwd_sel1),
        .fwd_sel2   (fwd_sel2),
        .mem_ctrl   (mem_ctrl),
        .mem_funct3 (mem_funct3),
        .addr3      (addr3),
        .wr         (wr)
    );

    // Combinational ROM returns NOP past the end of the program
    assign inst = (pc[31:ROM_AW+2] == '0) ? rom[pc[ROM_AW+1:2]] : rv_isa_pkg::INST_NOP;

    ////////////////////////////////////////
    // Expected decode from the ISA
    ////////////////////////////////////////

    function automatic rv_isa_pkg::inst_t rom_word(pipe_ctrl_pkg::pc_t addr);
        if (addr[31:ROM_AW+2] != '0)
            return rv_isa_pkg::INST_NOP;
        return rom[addr[ROM_AW+1:2]];
    endfunction

    function automatic logic reads_src1(rv_isa_pkg::opcode_t opc);
        case (opc)
            rv_isa_pkg::OPC_JALR, rv_isa_pkg::OPC_BRANCH, rv_isa_pkg::OPC_LOAD,
            rv_isa_pkg::OPC_STORE, rv_isa_pkg::OPC_OP_IMM, rv_isa_pkg::OPC_OP:
                return 1'b1;
            default:
                return 1'b0;
        endcase
    endfunction

    function automatic logic reads_src2(rv_isa_pkg::opcode_t opc);
        case (opc)
            rv_isa_pkg::OPC_BRANCH, rv_isa_pkg::OPC_STORE, rv_isa_pkg::OPC_OP:
                return 1'b1;
            default:
                return 1'b0;
        endcase
    endfunction

    // Everything supported except branch and store has a destination
    function automatic logic has_dest(rv_isa_pkg::opcode_t opc);
        case (opc)
            rv_isa_pkg::OPC_LUI, rv_isa_pkg::OPC_AUIPC, rv_isa_pkg::OPC_JAL,
            rv_isa_pkg::OPC_JALR, rv_isa_pkg::OPC_LOAD, rv_isa_pkg::OPC_OP_IMM,
            rv_isa_pkg::OPC_OP:
                return 1'b1;
            default:
                return 1'b0;
        endcase
    endfunction

    // Immediate by format zero extended to 20 bits
    function automatic pipe_ctrl_pkg::imm_t imm_of(rv_isa_pkg::inst_t w);
        case (w[6:0])
            rv_isa_pkg::OPC_LUI, rv_isa_pkg::OPC_AUIPC:
                return w[31:12];
            rv_isa_pkg::OPC_JAL:
                return {w[31], w[19:12], w[20], w[30:21]};
            rv_isa_pkg::OPC_JALR, rv_isa_pkg::OPC_LOAD, rv_isa_pkg::OPC_OP_IMM:
                return {8'd0, w[31:20]};
            rv_isa_pkg::OPC_BRANCH:
                return {8'd0, w[31], w[7], w[30:25], w[11:8]};
            rv_isa_pkg::OPC_STORE:
                return {8'd0, w[31:25], w[11:7]};
            rv_isa_pkg::OPC_OP:
                return {13'd0, w[31:25]};
            default:
                return '0;
        endcase
    endfunction

    // Nearer producer first and x0 never forwarded
    function automatic pipe_ctrl_pkg::fwd_sel_t fwd_pick(logic [4:0] src, logic [4:0] rd_mem,
                                                         logic [4:0] rd_wb);
        if (src != 5'd0 && src == rd_mem)
            return pipe_ctrl_pkg::FWD_MEM;
        if (src != 5'd0 && src == rd_wb)
            return pipe_ctrl_pkg::FWD_WB;
        return pipe_ctrl_pkg::FWD_NONE;
    endfunction

    // Fetched word reads the destination of a load sitting in stage 0
    function automatic logic load_hazard(rv_isa_pkg::inst_t older, rv_isa_pkg::inst_t young);
        if (older[6:0] != rv_isa_pkg::OPC_LOAD)
            return 1'b0;
        return (reads_src1(young[6:0]) && young[19:15] == older[11:7])
            || (reads_src2(young[6:0]) && young[24:20] == older[11:7]);
    endfunction

    task automatic update_expected();
        rv_isa_pkg::inst_t rr_w;
        rv_isa_pkg::inst_t ex_w;
        rv_isa_pkg::inst_t mem_w;
        rv_isa_pkg::inst_t wb_w;
        rr_w = hist[2];
        ex_w = hist[3];
        mem_w = hist[4];
        wb_w = hist[5];
        exp_addr1 = rr_w[19:15];
        exp_addr2 = rr_w[24:20];
        exp_rd1 = reads_src1(rr_w[6:0]);
        exp_rd2 = reads_src2(rr_w[6:0]);
        exp_dp = ex_w[6:0];
        exp_f3 = ex_w[14:12];
        exp_imm = imm_of(ex_w);
        // Producers are the two words accepted just before including bubbles
        exp_fwd1 = fwd_pick(ex_w[19:15], mem_w[11:7], wb_w[11:7]);
        exp_fwd2 = fwd_pick(ex_w[24:20], mem_w[11:7], wb_w[11:7]);
        exp_mem = mem_w[6:0];
        exp_mf3 = mem_w[14:12];
        exp_addr3 = wb_w[11:7];
        exp_wr = has_dest(wb_w[6:0]);
    endtask

    task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] want);
        err_count++;
        $display("Mismatch %s: got 0x%0h expected 0x%0h at %0t", name, got, want, $time);
    endtask

    ////////////////////////////////////////
    // Clock, reset and timeout
    ////////////////////////////////////////

    initial
    begin
        forever
        begin
            #4 clk = ~clk;
        end
    end

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("Timeout, the program did not finish within %0d cycles", cycle_count);
            $display("Checks stopped with %0d mismatches", err_count);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    always @(posedge clk)
    begin
        if (!arst_n)
        begin
            exp_pc = '0;
            stall_q = 1'b0;
            bubble_hist = '0;
            hist.delete();
            // Pipe is full of NOPs after reset
            for (int k = 0; k < 6; k++)
            begin
                hist.push_back(rv_isa_pkg::INST_NOP);
            end
            // Decoder registers read zero until the first edge
            {exp_addr1, exp_addr2, exp_rd1, exp_rd2, exp_dp, exp_f3, exp_imm} = '0;
            {exp_fwd1, exp_fwd2, exp_mem, exp_mf3, exp_addr3, exp_wr} = '0;
        end
        else
        begin
            fetched = rom_word(exp_pc);
            // At most one bubble per hazard
            stall_now = load_hazard(hist[0], fetched) && !stall_q;
            hist.push_front(stall_now ? rv_isa_pkg::INST_NOP : fetched);
            void'(hist.pop_back());
            bubble_hist = {bubble_hist[2:0], stall_now};
            if (stall_now)
                stall_count++;
            else
                exp_pc = exp_pc + 32'd4;
            stall_q = stall_now;
            update_expected();
        end
    end

    ////////////////////////////////////////
    // Checks sampled on the falling edge
    ////////////////////////////////////////

    // PC advance and load-use hold
    assert property (@(negedge clk) pc == exp_pc)
        else report_mismatch("pc", pc, exp_pc);

    // Register read two edges after acceptance
    assert property (@(negedge clk) addr1 == exp_addr1)
        else report_mismatch("addr1", 32'(addr1), 32'(exp_addr1));
    assert property (@(negedge clk) addr2 == exp_addr2)
        else report_mismatch("addr2", 32'(addr2), 32'(exp_addr2));
    assert property (@(negedge clk) rd1 == exp_rd1)
        else report_mismatch("rd1", 32'(rd1), 32'(exp_rd1));
    assert property (@(negedge clk) rd2 == exp_rd2)
        else report_mismatch("rd2", 32'(rd2), 32'(exp_rd2));

    // Execute controls and forwarding three edges after acceptance
    assert property (@(negedge clk) dp_ctrl == exp_dp)
        else report_mismatch("dp_ctrl", 32'(dp_ctrl), 32'(exp_dp));
    assert property (@(negedge clk) funct3 == exp_f3)
        else report_mismatch("funct3", 32'(funct3), 32'(exp_f3));
    assert property (@(negedge clk) immediate == exp_imm)
        else report_mismatch("immediate", 32'(immediate), 32'(exp_imm));
    assert property (@(negedge clk) fwd_sel1 == exp_fwd1)
        else report_mismatch("fwd_sel1", 32'(fwd_sel1), 32'(exp_fwd1));
    assert property (@(negedge clk) fwd_sel2 == exp_fwd2)
        else report_mismatch("fwd_sel2", 32'(fwd_sel2), 32'(exp_fwd2));

    // Stall bubble shows up in execute as ADDI with zero immediate
    assert property (@(negedge clk) !bubble_hist[3] || dp_ctrl == rv_isa_pkg::OPC_OP_IMM)
        else report_mismatch("dp_ctrl", 32'(dp_ctrl), 32'(rv_isa_pkg::OPC_OP_IMM));
    assert property (@(negedge clk) !bubble_hist[3] || immediate == '0)
        else report_mismatch("immediate", 32'(immediate), 32'h0);

    // Memory after four edges and write back after five
    assert property (@(negedge clk) mem_ctrl == exp_mem)
        else report_mismatch("mem_ctrl", 32'(mem_ctrl), 32'(exp_mem));
    assert property (@(negedge clk) mem_funct3 == exp_mf3)
        else report_mismatch("mem_funct3", 32'(mem_funct3), 32'(exp_mf3));
    assert property (@(negedge clk) addr3 == exp_addr3)
        else report_mismatch("addr3", 32'(addr3), 32'(exp_addr3));
    assert property (@(negedge clk) wr == exp_wr)
        else report_mismatch("wr", 32'(wr), 32'(exp_wr));

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial
    begin
        load_program();
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        while (exp_pc < END_PC)
        begin
            @(negedge clk);
        end
        // Last word still has to drain to write back
        repeat (6) @(negedge clk);
        @(posedge clk);
        $display("Checks finished with %0d mismatches and %0d stalls", err_count, stall_count);
        if (err_count == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

//--- hw/pipeline_ctrl_top.sv
`timescale 1ns/1ps

module pipeline_ctrl_top
(
    input  logic clk,
    input  logic arst_n,
    input  rv_isa_pkg::inst_t inst,
    output pipe_ctrl_pkg::pc_t pc,
    output rv_isa_pkg::reg_addr_t addr1,
    output rv_isa_pkg::reg_addr_t addr2,
    output logic rd1,
    output logic rd2,
    output rv_isa_pkg::opcode_t dp_ctrl,
    output rv_isa_pkg::funct3_t funct3,
    output pipe_ctrl_pkg::imm_t immediate,
    output pipe_ctrl_pkg::fwd_sel_t fwd_sel1,
    output pipe_ctrl_pkg::fwd_sel_t fwd_sel2,
    output rv_isa_pkg::opcode_t mem_ctrl,
    output rv_isa_pkg::funct3_t mem_funct3,
    output rv_isa_pkg::reg_addr_t addr3,
    output logic wr
);

    // Word entering the pipe, fetched inst or a bubble
    rv_isa_pkg::inst_t issue_inst;

    // Stage words
    rv_isa_pkg::inst_t stage_inst_0;
    rv_isa_pkg::inst_t stage_inst_1;
    rv_isa_pkg::inst_t stage_inst_2;
    rv_isa_pkg::inst_t stage_inst_3;
    rv_isa_pkg::inst_t stage_inst_4;

    ////////////////////////////////////////
    // Input side
    ////////////////////////////////////////

    fetch_sequencer u_fetch_sequencer
    (
        .clk          (clk),
        .arst_n       (arst_n),
        .inst         (inst),
        .stage_inst_0 (stage_inst_0),
        .pc           (pc),
        .issue_inst   (issue_inst)
    );

    inst_pipeline u_inst_pipeline
    (
        .clk          (clk),
        .arst_n       (arst_n),
        .issue_inst   (issue_inst),
        .stage_inst_0 (stage_inst_0),
        .stage_inst_1 (stage_inst_1),
        .stage_inst_2 (stage_inst_2),
        .stage_inst_3 (stage_inst_3),
        .stage_inst_4 (stage_inst_4)
    );

    ////////////////////////////////////////
    // Per-stage decoders
    ////////////////////////////////////////

    operand_read_ctrl u_operand_read_ctrl
    (
        .clk          (clk),
        .arst_n       (arst_n),
        .stage_inst_1 (stage_inst_1),
        .addr1        (addr1),
        .addr2        (addr2),
        .rd1          (rd1),
        .rd2          (rd2)
    );

    execute_ctrl u_execute_ctrl
    (
        .clk          (clk),
        .arst_n       (arst_n),
        .stage_inst_2 (stage_inst_2),
        .dp_ctrl      (dp_ctrl),
        .funct3       (funct3),
        .immediate    (immediate)
    );

    // Compares execute sources with the two older destinations
    forward_detect u_forward_detect
    (
        .clk          (clk),
        .arst_n       (arst_n),
        .stage_inst_2 (stage_inst_2),
        .stage_inst_3 (stage_inst_3),
        .stage_inst_4 (stage_inst_4),
        .fwd_sel1     (fwd_sel1),
        .fwd_sel2     (fwd_sel2)
    );

    mem_wb_ctrl u_mem_wb_ctrl
    (
        .clk          (clk),
        .arst_n       (arst_n),
        .stage_inst_3 (stage_inst_3),
        .stage_inst_4 (stage_inst_4),
        .mem_ctrl     (mem_ctrl),
        .mem_funct3   (mem_funct3),
        .addr3        (addr3),
        .wr           (wr)
    );

endmodule

//--- hw/mem_wb_ctrl.sv
`timescale 1ns/1ps

module mem_wb_ctrl
(
    input  logic clk,
    input  logic arst_n,
    input  rv_isa_pkg::inst_t stage_inst_3,
    input  rv_isa_pkg::inst_t stage_inst_4,
    output rv_isa_pkg::opcode_t mem_ctrl,
    output rv_isa_pkg::funct3_t mem_funct3,
    output rv_isa_pkg::reg_addr_t addr3,
    output logic wr
);

    rv_isa_pkg::opcode_t wb_opc;

    assign wb_opc = stage_inst_4[rv_isa_pkg::OPCODE_LSB +: rv_isa_pkg::OPCODE_W];

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            mem_ctrl <= '0;
            mem_funct3 <= '0;
            addr3 <= '0;
            wr <= 1'b0;
        end
        else
        begin
            // Memory stage, opcode and width/sign from funct3
            mem_ctrl <= stage_inst_3[rv_isa_pkg::OPCODE_LSB +: rv_isa_pkg::OPCODE_W];
            mem_funct3 <= stage_inst_3[rv_isa_pkg::FUNCT3_LSB +: rv_isa_pkg::FUNCT3_W];
            // Write back stage, destination and write port enable
            addr3 <= stage_inst_4[rv_isa_pkg::RD_LSB +: rv_isa_pkg::REG_ADDR_W];
            wr <= rv_isa_pkg::writes_rd(wb_opc);
        end
    end

endmodule

//--- hw/execute_ctrl.sv
`timescale 1ns/1ps

module execute_ctrl
(
    input  logic clk,
    input  logic arst_n,
    input  rv_isa_pkg::inst_t stage_inst_2,
    output rv_isa_pkg::opcode_t dp_ctrl,
    output rv_isa_pkg::funct3_t funct3,
    output pipe_ctrl_pkg::imm_t immediate
);

    rv_isa_pkg::inst_t ex_inst;
    rv_isa_pkg::opcode_t ex_opc;
    pipe_ctrl_pkg::imm_t imm_next;

    assign ex_inst = stage_inst_2;
    assign ex_opc = ex_inst[rv_isa_pkg::OPCODE_LSB +: rv_isa_pkg::OPCODE_W];

    ////////////////////////////////////////
    // Immediate assembly by format
    ////////////////////////////////////////

    always_comb
    begin
        imm_next = '0;
        case (ex_opc)
            // U type, upper 20 bits
            rv_isa_pkg::OPC_LUI,
            rv_isa_pkg::OPC_AUIPC:
                imm_next = ex_inst[31:12];
            // J type, scrambled offset bits 20:1
            rv_isa_pkg::OPC_JAL:
                imm_next = {ex_inst[31], ex_inst[19:12], ex_inst[20], ex_inst[30:21]};
            // I type
            rv_isa_pkg::OPC_JALR,
            rv_isa_pkg::OPC_LOAD,
            rv_isa_pkg::OPC_OP_IMM:
                imm_next = {8'd0, ex_inst[31:20]};
            // B type, offset bits 12:1
            rv_isa_pkg::OPC_BRANCH:
                imm_next = {8'd0, ex_inst[31], ex_inst[7], ex_inst[30:25], ex_inst[11:8]};
            // S type, split field
            rv_isa_pkg::OPC_STORE:
                imm_next = {8'd0, ex_inst[31:25], ex_inst[11:7]};
            // R type, funct7 for the ALU
            rv_isa_pkg::OPC_OP:
                imm_next = {13'd0, ex_inst[31:25]};
            // Unsupported opcodes give zero
            default:
                imm_next = '0;
        endcase
    end

    ////////////////////////////////////////
    // Datapath control registers
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            dp_ctrl <= '0;
            funct3 <= '0;
            immediate <= '0;
        end
        else
        begin
            dp_ctrl <= ex_opc;
            funct3 <= ex_inst[rv_isa_pkg::FUNCT3_LSB +: rv_isa_pkg::FUNCT3_W];
            immediate <= imm_next;
        end
    end

endmodule

//--- hw/operand_read_ctrl.sv
`timescale 1ns/1ps

module operand_read_ctrl
(
    input  logic clk,
    input  logic arst_n,
    input  rv_isa_pkg::inst_t stage_inst_1,
    output rv_isa_pkg::reg_addr_t addr1,
    output rv_isa_pkg::reg_addr_t addr2,
    output logic rd1,
    output logic rd2
);

    rv_isa_pkg::opcode_t rr_opc;

    assign rr_opc = stage_inst_1[rv_isa_pkg::OPCODE_LSB +: rv_isa_pkg::OPCODE_W];

    ////////////////////////////////////////
    // Register file read port controls
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            addr1 <= '0;
            addr2 <= '0;
            rd1 <= 1'b0;
            rd2 <= 1'b0;
        end
        else
        begin
            // Addresses pass through whatever the format
            addr1 <= stage_inst_1[rv_isa_pkg::RS1_LSB +: rv_isa_pkg::REG_ADDR_W];
            addr2 <= stage_inst_1[rv_isa_pkg::RS2_LSB +: rv_isa_pkg::REG_ADDR_W];
            // Enables only for formats that read the port
            rd1 <= rv_isa_pkg::uses_rs1(rr_opc);
            rd2 <= rv_isa_pkg::uses_rs2(rr_opc);
        end
    end

endmodule

//--- hw/forward_detect.sv
`timescale 1ns/1ps

module forward_detect
(
    input  logic clk,
    input  logic arst_n,
    input  rv_isa_pkg::inst_t stage_inst_2,
    input  rv_isa_pkg::inst_t stage_inst_3,
    input  rv_isa_pkg::inst_t stage_inst_4,
    output pipe_ctrl_pkg::fwd_sel_t fwd_sel1,
    output pipe_ctrl_pkg::fwd_sel_t fwd_sel2
);

    // Priority pick for one source register
    // Nearer producer wins, x0 is never forwarded
    function automatic pipe_ctrl_pkg::fwd_sel_t pick_fwd(
        rv_isa_pkg::reg_addr_t src,
        rv_isa_pkg::reg_addr_t rd_mem,
        rv_isa_pkg::reg_addr_t rd_wb
    );
        if ((src != '0) && (src == rd_mem))
            return pipe_ctrl_pkg::FWD_MEM;
        else if ((src != '0) && (src == rd_wb))
            return pipe_ctrl_pkg::FWD_WB;
        else
            return pipe_ctrl_pkg::FWD_NONE;
    endfunction

    rv_isa_pkg::reg_addr_t ex_rs1;
    rv_isa_pkg::reg_addr_t ex_rs2;
    rv_isa_pkg::reg_addr_t mem_rd;
    rv_isa_pkg::reg_addr_t wb_rd;

    assign ex_rs1 = stage_inst_2[rv_isa_pkg::RS1_LSB +: rv_isa_pkg::REG_ADDR_W];
    assign ex_rs2 = stage_inst_2[rv_isa_pkg::RS2_LSB +: rv_isa_pkg::REG_ADDR_W];

    // rd field taken as is, opcode of the older word not checked
    assign mem_rd = stage_inst_3[rv_isa_pkg::RD_LSB +: rv_isa_pkg::REG_ADDR_W];
    assign wb_rd = stage_inst_4[rv_isa_pkg::RD_LSB +: rv_isa_pkg::REG_ADDR_W];

    // Selects line up with the execute controls
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            fwd_sel1 <= pipe_ctrl_pkg::FWD_NONE;
            fwd_sel2 <= pipe_ctrl_pkg::FWD_NONE;
        end
        else
        begin
            fwd_sel1 <= pick_fwd(ex_rs1, mem_rd, wb_rd);
            fwd_sel2 <= pick_fwd(ex_rs2, mem_rd, wb_rd);
        end
    end

endmodule

//--- hw/inst_pipeline.sv
`timescale 1ns/1ps

module inst_pipeline
(
    input  logic clk,
    input  logic arst_n,
    input  rv_isa_pkg::inst_t issue_inst,
    output rv_isa_pkg::inst_t stage_inst_0,
    output rv_isa_pkg::inst_t stage_inst_1,
    output rv_isa_pkg::inst_t stage_inst_2,
    output rv_isa_pkg::inst_t stage_inst_3,
    output rv_isa_pkg::inst_t stage_inst_4
);

    // One word per stage, index 0 is the youngest
    rv_isa_pkg::inst_t stage_q [pipe_ctrl_pkg::NUM_STAGES];

    // Shift every cycle, there is no back-pressure
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            // Pipe starts full of bubbles
            for (int k = 0; k < pipe_ctrl_pkg::NUM_STAGES; k++)
            begin
                stage_q[k] <= rv_isa_pkg::INST_NOP;
            end
        end
        else
        begin
            stage_q[0] <= issue_inst;
            for (int k = 1; k < pipe_ctrl_pkg::NUM_STAGES; k++)
            begin
                stage_q[k] <= stage_q[k-1];
            end
        end
    end

    // Stage taps for the decoders
    assign stage_inst_0 = stage_q[0];
    assign stage_inst_1 = stage_q[1];
    assign stage_inst_2 = stage_q[2];
    assign stage_inst_3 = stage_q[3];
    assign stage_inst_4 = stage_q[4];

endmodule

//--- hw/fetch_sequencer.sv
`timescale 1ns/1ps

module fetch_sequencer
(
    input  logic clk,
    input  logic arst_n,
    input  rv_isa_pkg::inst_t inst,
    input  rv_isa_pkg::inst_t stage_inst_0,
    output pipe_ctrl_pkg::pc_t pc,
    output rv_isa_pkg::inst_t issue_inst
);

    // Fields of the word coming back from instruction memory
    rv_isa_pkg::opcode_t fetch_opc;
    rv_isa_pkg::reg_addr_t fetch_rs1;
    rv_isa_pkg::reg_addr_t fetch_rs2;

    // Fields of the youngest instruction in the pipe
    rv_isa_pkg::opcode_t s0_opc;
    rv_isa_pkg::reg_addr_t s0_rd;

    logic rs1_hit;
    logic rs2_hit;
    logic load_use;
    logic stall;
    logic stall_q;

    assign fetch_opc = inst[rv_isa_pkg::OPCODE_LSB +: rv_isa_pkg::OPCODE_W];
    assign fetch_rs1 = inst[rv_isa_pkg::RS1_LSB +: rv_isa_pkg::REG_ADDR_W];
    assign fetch_rs2 = inst[rv_isa_pkg::RS2_LSB +: rv_isa_pkg::REG_ADDR_W];

    assign s0_opc = stage_inst_0[rv_isa_pkg::OPCODE_LSB +: rv_isa_pkg::OPCODE_W];
    assign s0_rd = stage_inst_0[rv_isa_pkg::RD_LSB +: rv_isa_pkg::REG_ADDR_W];

    ////////////////////////////////////////
    // Load-use detection
    ////////////////////////////////////////

    // Source compare only counts when the format really reads it
    assign rs1_hit = rv_isa_pkg::uses_rs1(fetch_opc) && (fetch_rs1 == s0_rd);
    assign rs2_hit = rv_isa_pkg::uses_rs2(fetch_opc) && (fetch_rs2 == s0_rd);

    // Load data is not ready one stage behind
    assign load_use = (s0_opc == rv_isa_pkg::OPC_LOAD) && (rs1_hit || rs2_hit);

    // One bubble per hazard, never two in a row
    assign stall = load_use && !stall_q;

    // Bubble goes in, the fetched word waits for the next edge
    assign issue_inst = stall ? rv_isa_pkg::INST_NOP : inst;

    ////////////////////////////////////////
    // PC and stall state
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            pc <= '0;
            stall_q <= 1'b0;
        end
        else
        begin
            stall_q <= stall;
            // Hold on a stall so the same word is fetched again
            if (!stall)
            begin
                pc <= pc + pipe_ctrl_pkg::PC_STEP;
            end
        end
    end

endmodule

//--- hw/pipe_ctrl_pkg.sv
package pipe_ctrl_pkg;

    ////////////////////////////////////////
    // Pipeline organization
    ////////////////////////////////////////

    // Fetch, register read, execute, memory, write back
    localparam int NUM_STAGES = 5;

    // Program counter
    typedef logic [rv_isa_pkg::XLEN-1:0] pc_t;
    localparam pc_t PC_STEP = 4;

    // Immediate as handed to the datapath, zero extended
    localparam int IMM_W = 20;
    typedef logic [IMM_W-1:0] imm_t;

    // Operand forwarding select
    typedef logic [1:0] fwd_sel_t;

    // Register file value
    localparam fwd_sel_t FWD_NONE = 2'd0;
    // Result one stage ahead
    localparam fwd_sel_t FWD_MEM = 2'd1;
    // Result two stages ahead
    localparam fwd_sel_t FWD_WB = 2'd2;

endpackage

//--- hw/rv_isa_pkg.sv
package rv_isa_pkg;

    ////////////////////////////////////////
    // Widths and base types
    ////////////////////////////////////////

    // Instruction word and address width
    localparam int XLEN = 32;
    localparam int REG_ADDR_W = 5;
    localparam int OPCODE_W = 7;
    localparam int FUNCT3_W = 3;

    typedef logic [XLEN-1:0] inst_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [OPCODE_W-1:0] opcode_t;
    typedef logic [FUNCT3_W-1:0] funct3_t;

    // Major opcodes handled by the pipeline
    localparam opcode_t OPC_LUI = 7'b0110111;
    localparam opcode_t OPC_AUIPC = 7'b0010111;
    localparam opcode_t OPC_JAL = 7'b1101111;
    localparam opcode_t OPC_JALR = 7'b1100111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_LOAD = 7'b0000011;
    localparam opcode_t OPC_STORE = 7'b0100011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_OP = 7'b0110011;

    // Low bit of each fixed field
    localparam int OPCODE_LSB = 0;
    localparam int RD_LSB = 7;
    localparam int FUNCT3_LSB = 12;
    localparam int RS1_LSB = 15;
    localparam int RS2_LSB = 20;

    // ADDI x0, x0, 0
    localparam inst_t INST_NOP = 32'h0000_0013;

    ////////////////////////////////////////
    // Operand use classification
    ////////////////////////////////////////

    // Reads rs1
    function automatic logic uses_rs1(opcode_t opc);
        return (opc == OPC_JALR) || (opc == OPC_BRANCH) || (opc == OPC_LOAD)
            || (opc == OPC_STORE) || (opc == OPC_OP_IMM) || (opc == OPC_OP);
    endfunction

    // Reads rs2, only the R, S and B formats
    function automatic logic uses_rs2(opcode_t opc);
        return (opc == OPC_BRANCH) || (opc == OPC_STORE) || (opc == OPC_OP);
    endfunction

    // Writes rd
    // Branch and store have no destination
    function automatic logic writes_rd(opcode_t opc);
        return (opc == OPC_LUI) || (opc == OPC_AUIPC) || (opc == OPC_JAL)
            || (opc == OPC_JALR) || (opc == OPC_LOAD) || (opc == OPC_OP_IMM)
            || (opc == OPC_OP);
    endfunction

endpackage
